/* hdl/network_sink.sv */
`timescale 1ns/1ps

module network_sink
    import snn_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  logic               net_valid,
    input  logic               net_last,
    output logic               net_ready,
    input  logic               net_arstn,
    input  logic [NUM_OUT-1:0] net_out,
    input  logic               snk_ready,
    output logic               snk_valid,
    output pkt_t               snk
);

    enum logic [1:0] {IDLE, RUNS, SPKS, CLRD} curr_state, next_state;

    // steps since the last RUN, FIN or CLR that were not yet reported
    logic [RUN_WIDTH-1:0] run_counter;

    // spikes and last flag of the step that opened the current RUN
    logic [NUM_OUT-1:0] fires;
    logic               last;

    // output index being offered while in SPKS
    logic [SPK_WIDTH-1:0] fire_idx;
    logic                 spk_adv;

    // set by a network reset and cleared once the CLR packet is taken
    logic rst_pend;
    logic step;

    // steps wait while a CLR is pending so that they follow it in the stream
    assign net_ready = (curr_state == IDLE) && !rst_pend;
    assign step      = net_valid && net_ready;

    // an index that did not fire is skipped without a handshake
    assign spk_adv = !fires[fire_idx] || snk_ready;

    always_ff @(posedge clk or negedge arstn or negedge net_arstn) begin
        if (!arstn) begin
            rst_pend <= 1'b0;
        end else if (!net_arstn) begin
            rst_pend <= 1'b1;
        end else if (curr_state == CLRD && snk_ready) begin
            rst_pend <= 1'b0;
        end
    end

    // the counter includes the step that triggers the RUN
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            run_counter <= '0;
        end else if (step) begin
            run_counter <= run_counter + 1'b1;
        end else if (curr_state == RUNS && snk_ready) begin
            run_counter <= '0;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            fires <= '0;
            last  <= 1'b0;
        end else if (curr_state == IDLE && next_state == RUNS) begin
            // a RUN flushed by a pending reset carries no spikes
            fires <= step ? net_out : '0;
            last  <= step && net_last;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            fire_idx <= '0;
        end else if (curr_state != SPKS) begin
            fire_idx <= '0;
        end else if (spk_adv) begin
            fire_idx <= fire_idx + 1'b1;
        end
    end

    always_comb begin
        snk       = '0;
        snk_valid = 1'b0;
        case (curr_state)
            RUNS: begin
                snk.run.pfx = last ? FIN : RUN;
                snk.run.cnt = run_counter;
                snk_valid   = 1'b1;
            end
            SPKS: begin
                snk.spk.pfx = SPK;
                snk.spk.idx = fire_idx;
                snk_valid   = fires[fire_idx];
            end
            CLRD: begin
                snk.run.pfx = CLR;
                snk_valid   = 1'b1;
            end
            default: begin
                snk_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        next_state = curr_state;
        case (curr_state)
            IDLE: begin
                if (rst_pend) begin
                    // unreported steps go out before the CLR
                    next_state = (run_counter != '0) ? RUNS : CLRD;
                end else if (step && (|net_out || net_last ||
                                      run_counter == RUN_WIDTH'(RUN_MAX - 1))) begin
                    next_state = RUNS;
                end
            end
            RUNS: begin
                if (snk_ready) begin
                    if (|fires) begin
                        next_state = SPKS;
                    end else if (rst_pend) begin
                        next_state = CLRD;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            SPKS: begin
                if (spk_adv && fire_idx == SPK_WIDTH'(NUM_OUT - 1)) begin
                    next_state = rst_pend ? CLRD : IDLE;
                end
            end
            CLRD: begin
                if (snk_ready) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            curr_state <= IDLE;
        end else begin
            curr_state <= next_state;
        end
    end

    // a stalled RUN or FIN keeps its count until the consumer takes it
    assert property (@(posedge clk) disable iff (!arstn)
        curr_state == RUNS && snk_valid && !snk_ready |=> $stable(snk));

endmodule

/* hdl/neuron_layer.sv */
`timescale 1ns/1ps

module neuron_layer
    import snn_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  logic               net_arstn,
    input  logic               net_valid,
    input  logic               net_ready,
    input  logic [NUM_INP-1:0] net_in,
    output logic [NUM_OUT-1:0] net_out
);

    // membrane potential of each output neuron
    logic [POT_WIDTH-1:0] pot [NUM_OUT];

    // potential plus the weighted inputs of the step on offer
    logic [POT_WIDTH-1:0] sum [NUM_OUT];

    // either the global reset or a network reset clears the potentials
    logic pot_arstn;
    logic step;

    assign pot_arstn = arstn && net_arstn;
    assign step      = net_valid && net_ready;

    always_comb begin
        for (int j = 0; j < NUM_OUT; j++) begin
            sum[j] = pot[j];
            for (int i = 0; i < NUM_INP; i++) begin
                if (net_in[i]) begin
                    sum[j] = sum[j] + POT_WIDTH'(WEIGHTS[i][j]);
                end
            end
            net_out[j] = sum[j] >= POT_WIDTH'(THRESHOLD);
        end
    end

    // a neuron that fires starts again from zero
    always_ff @(posedge clk or negedge pot_arstn) begin
        if (!pot_arstn) begin
            for (int j = 0; j < NUM_OUT; j++) begin
                pot[j] <= '0;
            end
        end else if (step) begin
            for (int j = 0; j < NUM_OUT; j++) begin
                pot[j] <= net_out[j] ? '0 : sum[j];
            end
        end
    end

    for (genvar j = 0; j < NUM_OUT; j++) begin : g_pot_check
        // the weighted inputs must never carry a sum past the potential width
        assert property (@(posedge clk) disable iff (!arstn)
            sum[j] >= pot[j]);
    end

endmodule

/* hdl/snn_core.sv */
`timescale 1ns/1ps

module snn_core
    import snn_pkg::*;
(
    input  logic clk,
    input  logic arstn,
    input  logic src_valid,
    input  pkt_t src,
    output logic src_ready,
    output logic snk_valid,
    input  logic snk_ready,
    output pkt_t snk
);

    // network step handshake shared by all three blocks
    logic net_valid;
    logic net_ready;
    logic net_last;

    // one-cycle network reset from the dispatcher
    logic net_arstn;

    logic [NUM_INP-1:0] net_in;
    logic [NUM_OUT-1:0] net_out;

    spike_dispatch dispatch0 (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src       (src),
        .src_ready (src_ready),
        .net_ready (net_ready),
        .net_valid (net_valid),
        .net_last  (net_last),
        .net_in    (net_in),
        .net_arstn (net_arstn)
    );

    // the layer only reads the handshake, the sink decides when a step is taken
    neuron_layer layer0 (
        .clk       (clk),
        .arstn     (arstn),
        .net_arstn (net_arstn),
        .net_valid (net_valid),
        .net_ready (net_ready),
        .net_in    (net_in),
        .net_out   (net_out)
    );

    network_sink sink0 (
        .clk       (clk),
        .arstn     (arstn),
        .net_valid (net_valid),
        .net_last  (net_last),
        .net_ready (net_ready),
        .net_arstn (net_arstn),
        .net_out   (net_out),
        .snk_ready (snk_ready),
        .snk_valid (snk_valid),
        .snk       (snk)
    );

endmodule

/* hdl/snn_pkg.sv */
package snn_pkg;

    // layer dimensions
    localparam int NUM_INP = 4;
    localparam int NUM_OUT = 4;

    // packet layout, a 2-bit opcode prefix followed by a count or an index
    localparam int PKT_WIDTH = 8;
    localparam int PFX_WIDTH = 2;
    localparam int SPK_WIDTH = $clog2(NUM_OUT);
    localparam int RUN_WIDTH = PKT_WIDTH - PFX_WIDTH;
    localparam int PAD_WIDTH = PKT_WIDTH - PFX_WIDTH - SPK_WIDTH;

    // an all ones run count is the saturation value
    localparam int RUN_MAX = 2 ** RUN_WIDTH - 1;

    localparam logic [PFX_WIDTH-1:0] RUN = 2'b00;
    localparam logic [PFX_WIDTH-1:0] SPK = 2'b01;
    localparam logic [PFX_WIDTH-1:0] FIN = 2'b10;
    localparam logic [PFX_WIDTH-1:0] CLR = 2'b11;

    // a stored potential stays below 8 and four weights add at most 28
    localparam int POT_WIDTH = 6;
    localparam int THRESHOLD = 8;
    localparam int WGT_WIDTH = 3;

    // indexed as WEIGHTS[input][output]
    localparam logic [WGT_WIDTH-1:0] WEIGHTS [NUM_INP][NUM_OUT] = '{
        '{3'd5, 3'd1, 3'd3, 3'd7},
        '{3'd2, 3'd6, 3'd0, 3'd4},
        '{3'd7, 3'd3, 3'd5, 3'd1},
        '{3'd1, 3'd4, 3'd6, 3'd2}
    };

    typedef union packed {
        struct packed {
            logic [PFX_WIDTH-1:0] pfx;
            logic [RUN_WIDTH-1:0] cnt;
        } run;
        struct packed {
            logic [PFX_WIDTH-1:0] pfx;
            logic [SPK_WIDTH-1:0] idx;
            logic [PAD_WIDTH-1:0] pad;
        } spk;
    } pkt_t;

endpackage

/* hdl/spike_dispatch.sv */
`timescale 1ns/1ps

module spike_dispatch
    import snn_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  logic               src_valid,
    input  pkt_t               src,
    output logic               src_ready,
    input  logic               net_ready,
    output logic               net_valid,
    output logic               net_last,
    output logic [NUM_INP-1:0] net_in,
    output logic               net_arstn
);

    // input spikes waiting for the next step
    logic [NUM_INP-1:0] pending;

    // steps still to be issued for the current RUN or FIN
    logic [RUN_WIDTH-1:0] remaining;

    // set while the steps in flight came from a FIN packet
    logic final_run;

    // high for the single cycle in which the network is held in reset
    logic rst_pulse;

    logic src_fire;
    logic net_fire;

    // new packets are taken only once all steps and any reset pulse are done
    assign src_ready = (remaining == '0) && !rst_pulse;
    assign src_fire  = src_valid && src_ready;

    assign net_valid = remaining != '0;
    assign net_fire  = net_valid && net_ready;
    assign net_last  = final_run && (remaining == RUN_WIDTH'(1));
    assign net_in    = pending;
    assign net_arstn = !rst_pulse;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            rst_pulse <= 1'b0;
        end else begin
            rst_pulse <= src_fire && (src.run.pfx == CLR);
        end
    end

    // pending spikes are applied on the first step of a run and dropped after it
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pending <= '0;
        end else if (src_fire) begin
            if (src.spk.pfx == SPK) begin
                pending[src.spk.idx] <= 1'b1;
            end else if (src.run.pfx == CLR) begin
                pending <= '0;
            end
        end else if (net_fire) begin
            pending <= '0;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            remaining <= '0;
            final_run <= 1'b0;
        end else if (src_fire && (src.run.pfx == RUN || src.run.pfx == FIN)) begin
            // a count of zero leaves remaining at zero and issues no step
            remaining <= src.run.cnt;
            final_run <= src.run.pfx == FIN;
        end else if (net_fire) begin
            remaining <= remaining - 1'b1;
        end
    end

    // a step offered to the layer must not be withdrawn or changed before it is taken
    assert property (@(posedge clk) disable iff (!arstn)
        net_valid && !net_ready |=> net_valid && $stable(net_in) && $stable(net_last));

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module snn_tb -f src.f -o snn_sim &&
./obj_dir/snn_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" ||
{ cat sim.log; exit 1; }

/* src.f */
+incdir+tb
hdl/snn_pkg.sv
hdl/spike_dispatch.sv
hdl/neuron_layer.sv
hdl/network_sink.sv
hdl/snn_core.sv
tb/snn_tb.sv

/* tb/snn_model.svh */
`ifndef SNN_MODEL_SVH
`define SNN_MODEL_SVH

// potentials, pending input spikes and unreported steps as the model sees them
logic [POT_WIDTH-1:0] model_pot [NUM_OUT];
logic [NUM_INP-1:0]   model_pend;
int                   model_steps;

// output packets still to come from the sink, oldest first
pkt_t exp_q [$];

function automatic pkt_t run_word(input logic [PFX_WIDTH-1:0] pfx, input int cnt);
    pkt_t word;
    word = '0;
    word.run.pfx = pfx;
    word.run.cnt = RUN_WIDTH'(cnt);
    return word;
endfunction

function automatic pkt_t spk_word(input int idx);
    pkt_t word;
    word = '0;
    word.spk.pfx = SPK;
    word.spk.idx = SPK_WIDTH'(idx);
    return word;
endfunction

task automatic clear_network();
    for (int j = 0; j < NUM_OUT; j++) begin
        model_pot[j] = '0;
    end
    model_pend  = '0;
    model_steps = 0;
endtask

// one integrate-and-fire step followed by the sink's run length encoding
task automatic step_layer(input logic [NUM_INP-1:0] inp, input bit is_last);
    int                 sum;
    logic [NUM_OUT-1:0] fired;
    fired = '0;
    for (int j = 0; j < NUM_OUT; j++) begin
        sum = int'(model_pot[j]);
        for (int i = 0; i < NUM_INP; i++) begin
            if (inp[i]) begin
                sum += int'(WEIGHTS[i][j]);
            end
        end
        fired[j]     = sum >= THRESHOLD;
        model_pot[j] = fired[j] ? '0 : POT_WIDTH'(sum);
    end
    model_steps++;
    if (fired != '0 || is_last || model_steps == RUN_MAX) begin
        exp_q.push_back(run_word(is_last ? FIN : RUN, model_steps));
        model_steps = 0;
        for (int j = 0; j < NUM_OUT; j++) begin
            if (fired[j]) begin
                exp_q.push_back(spk_word(j));
            end
        end
    end
endtask

task automatic apply_packet(input pkt_t word);
    int n;
    case (word.run.pfx)
        SPK: begin
            model_pend[word.spk.idx] = 1'b1;
        end
        RUN, FIN: begin
            n = int'(word.run.cnt);
            // pending spikes only reach the first step of the run
            for (int k = 0; k < n; k++) begin
                step_layer(model_pend, word.run.pfx == FIN && k == n - 1);
                model_pend = '0;
            end
        end
        default: begin
            // steps not yet reported go out as a RUN ahead of the CLR
            if (model_steps != 0) begin
                exp_q.push_back(run_word(RUN, model_steps));
            end
            exp_q.push_back(run_word(CLR, 0));
            clear_network();
        end
    endcase
endtask

`endif

/* tb/snn_tb.sv */
`timescale 1ns/1ps

module snn_tb
    import snn_pkg::*;
();

    localparam int NUM_RANDOM  = 200;
    localparam int NUM_PKTS    = NUM_RANDOM + 10;
    localparam int CYCLE_LIMIT = NUM_PKTS * 80;

    // room for two full runs behind the last packet plus stalled output packets
    localparam int DRAIN_LIMIT = 400;

    logic clk;
    logic arstn;
    logic src_valid;
    logic src_ready;
    logic snk_valid;
    logic snk_ready;
    pkt_t src;
    pkt_t snk;

    logic [31:0] lfsr;
    pkt_t        stim_q [$];
    int          next_pkt;
    int          accepted;
    int          checked;
    int          errors;
    int          ready_left;
    int          drain_cycles;

    // CLR packets sent but not yet seen at the output
    int          clr_waiting;

    `include "snn_model.svh"

    snn_core dut0 (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src       (src),
        .src_ready (src_ready),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready),
        .snk       (snk)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1, one shift per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic build_stimulus();
        int sel;
        // two quiet runs of 40 steps saturate the count, then spikes around two resets
        stim_q.push_back(run_word(RUN, 40));
        stim_q.push_back(run_word(RUN, 40));
        stim_q.push_back(run_word(FIN, 5));
        stim_q.push_back(spk_word(0));
        stim_q.push_back(spk_word(2));
        stim_q.push_back(run_word(RUN, 3));
        stim_q.push_back(run_word(CLR, 0));
        stim_q.push_back(run_word(RUN, 2));
        stim_q.push_back(run_word(CLR, 0));
        stim_q.push_back(run_word(FIN, 1));
        for (int k = 0; k < NUM_RANDOM; k++) begin
            sel = take_bits(4);
            if (sel < 6) begin
                stim_q.push_back(spk_word(take_bits(SPK_WIDTH)));
            end else if (sel < 12) begin
                stim_q.push_back(run_word(RUN, take_bits(3)));
            end else if (sel < 14) begin
                stim_q.push_back(run_word(RUN, take_bits(RUN_WIDTH)));
            end else if (sel < 15) begin
                stim_q.push_back(run_word(FIN, take_bits(3)));
            end else begin
                stim_q.push_back(run_word(CLR, 0));
            end
        end
    endtask

    // handshakes are judged at the falling edge, inputs change just after the rising edge
    task automatic run_cycle(input bit sending);
        bit   took;
        pkt_t word;
        @(negedge clk);
        took = src_valid && src_ready;
        if (took) begin
            apply_packet(src);
            accepted++;
            clr_waiting += (src.run.pfx == CLR) ? 1 : 0;
        end
        if (snk_valid && snk_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output packet %h appeared at %0t with none expected", snk, $time);
            end else begin
                word = exp_q.pop_front();
                check_value(32'(snk), 32'(word), "output packet");
                checked++;
                clr_waiting -= (word.run.pfx == CLR) ? 1 : 0;
            end
        end
        @(posedge clk);
        #1;
        if (ready_left == 0) begin
            snk_ready  = take_bits(2) != 0;
            ready_left = take_bits(3);
        end else begin
            ready_left--;
        end
        if (took || !src_valid) begin
            src_valid = 1'b0;
            // a second CLR waits until the first has left, so the two are not merged
            if (sending && next_pkt < stim_q.size() &&
                !(stim_q[next_pkt].run.pfx == CLR && clr_waiting > 0)) begin
                src       = stim_q[next_pkt];
                src_valid = 1'b1;
                next_pkt++;
            end
        end
    endtask

    initial begin
        arstn        = 1'b0;
        src_valid    = 1'b0;
        src          = '0;
        snk_ready    = 1'b0;
        lfsr         = 32'h2fc2_6eb5;
        next_pkt     = 0;
        accepted     = 0;
        checked      = 0;
        errors       = 0;
        ready_left   = 0;
        drain_cycles = 0;
        clr_waiting  = 0;
        clear_network();
        build_stimulus();
        repeat (3) @(posedge clk);
        #1;
        arstn = 1'b1;
        // nothing may come out while no packet goes in
        repeat (10) begin
            run_cycle(1'b0);
            check_value(32'(snk_valid), 32'd0, "snk_valid while idle");
            check_value(32'(src_ready), 32'd1, "src_ready while idle");
        end
        while (next_pkt < stim_q.size()) begin
            run_cycle(1'b1);
        end
        // the last packet and the packets still owed get a bounded time to come through
        while ((src_valid || !src_ready || exp_q.size() != 0) &&
               drain_cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            drain_cycles++;
        end
        repeat (20) run_cycle(1'b0);
        check_value(32'(accepted), 32'(stim_q.size()), "accepted packet count");
        check_value(32'(exp_q.size()), 32'd0, "expected packets left over");
        $display("%0d packets in, %0d packets checked, %0d errors", accepted, checked, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("Run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
